//--- hw/pp_host_pkg.sv
package pp_host_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Channels
	////////////////////////////////////////////////////////////////////////////
	localparam int NUM_CH     = 16;
	localparam int DELAY_BITS = 4;

	typedef logic [NUM_CH-1:0]            ch_mask_t;
	typedef logic [NUM_CH*DELAY_BITS-1:0] ch_delay_t;

	////////////////////////////////////////////////////////////////////////////
	// APB, no wait states and no slave error
	////////////////////////////////////////////////////////////////////////////
	localparam int APB_AW = 12;
	localparam int APB_DW = 32;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
	} apb_rsp_t;

	// Register map, byte addresses
	localparam logic [APB_AW-1:0] REG_CTRL         = 12'h000;
	localparam logic [APB_AW-1:0] REG_STATUS       = 12'h004;
	localparam logic [APB_AW-1:0] REG_HOST_SHUTTER = 12'h008;
	localparam logic [APB_AW-1:0] REG_TRIG_MASK    = 12'h00C;
	localparam logic [APB_AW-1:0] REG_DELAY_LO     = 12'h010;
	localparam logic [APB_AW-1:0] REG_DELAY_HI     = 12'h014;
	localparam logic [APB_AW-1:0] REG_CONFIG       = 12'h018;
	localparam logic [APB_AW-1:0] CMD_BASE         = 12'h100;

	// Bit positions
	localparam int CTRL_START    = 0;
	localparam int CTRL_STOP     = 1;
	localparam int CTRL_FIRE     = 2;
	localparam int CTRL_APPLY    = 3;
	localparam int STAT_ACTIVE   = 0;
	localparam int STAT_PC_LSB   = 8;
	localparam int CFG_APPLY_IMM = 0;

	// Effective host settings as seen by the output stage
	typedef struct packed {
		ch_mask_t  shutter;
		ch_mask_t  trig_mask;
		ch_delay_t delay;
	} host_cfg_t;

endpackage

//--- hw/pp_cmd_pkg.sv
package pp_cmd_pkg;

	import pp_host_pkg::*;

	localparam int CMD_ADDR_W = 6;
	localparam int WAIT_W     = 24;

	// Zero decodes as END so that a cleared word stops the run
	typedef enum logic [3:0] {
		OP_END     = 4'h0,
		OP_SHUTTER = 4'h1,
		OP_TRIGGER = 4'h2,
		OP_WAIT    = 4'h3
	} opcode_e;

	// SHUTTER and TRIGGER carry a channel mask
	typedef struct packed {
		opcode_e    op;
		logic [11:0] rsvd;
		ch_mask_t   mask;
	} cmd_ch_t;

	// WAIT carries a cycle count
	typedef struct packed {
		opcode_e           op;
		logic [3:0]        rsvd;
		logic [WAIT_W-1:0] count;
	} cmd_wait_t;

	// One 32-bit command word, opcode in the same place in both views
	typedef union packed {
		cmd_ch_t   ch;
		cmd_wait_t wt;
	} cmd_word_u;

endpackage

//--- hw/pp_apb_regs.sv
`timescale 1ns/1ps

module pp_apb_regs
	import pp_host_pkg::*;
	import pp_cmd_pkg::*;
#(
	parameter int CMD_DEPTH = 64
) (
	input  logic                  clk,
	input  logic                  ti_reset,
	input  apb_req_t              apb_i,
	output apb_rsp_t              apb_o,
	input  cmd_word_u             cmd_rdata_i,
	input  logic                  seq_active_i,
	input  logic [CMD_ADDR_W-1:0] seq_pc_i,
	output host_cfg_t             cfg_o,
	output ch_mask_t              host_trig_o,
	output logic                  start_o,
	output logic                  stop_o,
	output logic                  cmd_we_o,
	output logic [CMD_ADDR_W-1:0] cmd_addr_o,
	output cmd_word_u             cmd_wdata_o
);

	localparam int HALF_DW = NUM_CH * DELAY_BITS / 2;
	localparam logic [APB_AW-1:0] CMD_END = CMD_BASE + APB_AW'(4 * CMD_DEPTH);

	logic               setup_ph, access_ph, wr_en, in_cmd;
	logic               wr_ctrl, wr_staged;
	logic [APB_AW-1:0]  cmd_off;
	logic [APB_DW-1:0]  rdata_nxt, rdata_q;
	logic               rd_cmd_q;

	// Shadow copies, written by the host
	ch_mask_t           shutter_sh, trig_sh;
	logic [HALF_DW-1:0] delay_lo_sh, delay_hi_sh;
	logic               apply_imm_q, apply_q;

	host_cfg_t          cfg_q;
	ch_mask_t           host_trig_q;
	logic               start_q, stop_q;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////
	assign setup_ph  = apb_i.psel && !apb_i.penable;
	assign access_ph = apb_i.psel && apb_i.penable;
	assign wr_en     = access_ph && apb_i.pwrite;
	assign in_cmd    = (apb_i.paddr >= CMD_BASE) && (apb_i.paddr < CMD_END);
	assign wr_ctrl   = wr_en && (apb_i.paddr == REG_CTRL);
	assign wr_staged = wr_en && ((apb_i.paddr == REG_HOST_SHUTTER) ||
		(apb_i.paddr == REG_TRIG_MASK) || (apb_i.paddr == REG_DELAY_LO) ||
		(apb_i.paddr == REG_DELAY_HI));

	// Command memory sees the address already in the setup phase
	assign cmd_off     = apb_i.paddr - CMD_BASE;
	assign cmd_addr_o  = cmd_off[CMD_ADDR_W+1:2];
	assign cmd_we_o    = wr_en && in_cmd;
	assign cmd_wdata_o = apb_i.pwdata;

	////////////////////////////////////////////////////////////////////////////
	// Host writes
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (ti_reset) begin
			shutter_sh  <= '0;
			trig_sh     <= '0;
			delay_lo_sh <= '0;
			delay_hi_sh <= '0;
			apply_imm_q <= 1'b0;
			apply_q     <= 1'b0;
			cfg_q       <= '0;
			host_trig_q <= '0;
			start_q     <= 1'b0;
			stop_q      <= 1'b0;
		end else begin
			if (wr_en) begin
				case (apb_i.paddr)
					REG_HOST_SHUTTER: shutter_sh  <= apb_i.pwdata[NUM_CH-1:0];
					REG_TRIG_MASK:    trig_sh     <= apb_i.pwdata[NUM_CH-1:0];
					REG_DELAY_LO:     delay_lo_sh <= apb_i.pwdata[HALF_DW-1:0];
					REG_DELAY_HI:     delay_hi_sh <= apb_i.pwdata[HALF_DW-1:0];
					REG_CONFIG:       apply_imm_q <= apb_i.pwdata[CFG_APPLY_IMM];
					default: ;
				endcase
			end
			// Shadow to effective one cycle after the write or the apply
			apply_q <= (wr_ctrl && apb_i.pwdata[CTRL_APPLY]) || (wr_staged && apply_imm_q);
			if (apply_q) begin
				cfg_q.shutter   <= shutter_sh;
				cfg_q.trig_mask <= trig_sh;
				cfg_q.delay     <= {delay_hi_sh, delay_lo_sh};
			end
			host_trig_q <= (wr_ctrl && apb_i.pwdata[CTRL_FIRE]) ? cfg_q.trig_mask : '0;
			start_q     <= wr_ctrl && apb_i.pwdata[CTRL_START];
			stop_q      <= wr_ctrl && apb_i.pwdata[CTRL_STOP];
		end
	end

	assign cfg_o       = cfg_q;
	assign host_trig_o = host_trig_q;
	assign start_o     = start_q;
	assign stop_o      = stop_q;

	////////////////////////////////////////////////////////////////////////////
	// Readback, captured in the setup phase
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		rdata_nxt = '0;
		case (apb_i.paddr)
			REG_STATUS: begin
				rdata_nxt[STAT_ACTIVE]               = seq_active_i;
				rdata_nxt[STAT_PC_LSB +: CMD_ADDR_W] = seq_pc_i;
			end
			REG_HOST_SHUTTER: rdata_nxt[NUM_CH-1:0]  = shutter_sh;
			REG_TRIG_MASK:    rdata_nxt[NUM_CH-1:0]  = trig_sh;
			REG_DELAY_LO:     rdata_nxt[HALF_DW-1:0] = delay_lo_sh;
			REG_DELAY_HI:     rdata_nxt[HALF_DW-1:0] = delay_hi_sh;
			REG_CONFIG:       rdata_nxt[CFG_APPLY_IMM] = apply_imm_q;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			rdata_q  <= '0;
			rd_cmd_q <= 1'b0;
		end else begin
			if (setup_ph) begin
				rdata_q <= rdata_nxt;
			end
			rd_cmd_q <= setup_ph && in_cmd;
		end
	end

	assign apb_o.prdata = rd_cmd_q ? cmd_rdata_i : rdata_q;
	assign apb_o.pready = 1'b1;

	// Every access phase comes right after the setup phase of its transfer
	a_apb_setup_first: assert property (@(posedge clk) disable iff (ti_reset)
		apb_i.penable |-> apb_i.psel && $past(apb_i.psel && !apb_i.penable));

endmodule

//--- hw/pp_cmd_mem.sv
`timescale 1ns/1ps

module pp_cmd_mem
	import pp_cmd_pkg::*;
#(
	parameter int CMD_DEPTH = 64
) (
	input  logic                  clk,
	input  logic                  we_i,
	input  logic [CMD_ADDR_W-1:0] waddr_i,
	input  cmd_word_u             wdata_i,
	input  logic [CMD_ADDR_W-1:0] host_raddr_i,
	input  logic [CMD_ADDR_W-1:0] fetch_addr_i,
	output cmd_word_u             host_rdata_o,
	output cmd_word_u             fetch_data_o
);

	// Program store, one command per word
	cmd_word_u mem_q [CMD_DEPTH];

	// Single write port, owned by the host
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem_q[waddr_i] <= wdata_i;
		end
	end

	// Host readback port
	// Old data is returned when read and write hit the same word
	always_ff @(posedge clk) begin
		host_rdata_o <= mem_q[host_raddr_i];
	end

	// Sequencer fetch port
	always_ff @(posedge clk) begin
		fetch_data_o <= mem_q[fetch_addr_i];
	end

endmodule

//--- hw/pp_sequencer.sv
`timescale 1ns/1ps

module pp_sequencer
	import pp_host_pkg::*;
	import pp_cmd_pkg::*;
#(
	parameter int CMD_DEPTH = 64
) (
	input  logic                  clk,
	input  logic                  ti_reset,
	input  logic                  start_i,
	input  logic                  stop_i,
	input  cmd_word_u             cmd_i,
	input  logic                  timer_expired_i,
	output logic [CMD_ADDR_W-1:0] fetch_addr_o,
	output logic                  timer_load_o,
	output logic [WAIT_W-1:0]     timer_count_o,
	output logic                  active_o,
	output logic [CMD_ADDR_W-1:0] pc_o,
	output ch_mask_t              shutter_o,
	output ch_mask_t              trigger_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_WAIT
	} state_e;

	state_e                state_q;
	logic [CMD_ADDR_W-1:0] pc_q, pc_next;
	logic                  active_q;
	ch_mask_t              shutter_q, trigger_q;

	assign pc_next = (pc_q == CMD_ADDR_W'(CMD_DEPTH - 1)) ? '0 : pc_q + 1'b1;

	// Memory answers one cycle after the fetch address
	assign fetch_addr_o = pc_q;

	// WAIT 0 needs no timer and falls through like a two-cycle command
	assign timer_load_o  = (state_q == S_EXEC) && (cmd_i.wt.op == OP_WAIT) &&
		(cmd_i.wt.count != '0);
	assign timer_count_o = cmd_i.wt.count;

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			state_q   <= S_IDLE;
			pc_q      <= '0;
			active_q  <= 1'b0;
			shutter_q <= '0;
			trigger_q <= '0;
		end else begin
			trigger_q <= '0;
			if (stop_i) begin
				state_q  <= S_IDLE;
				active_q <= 1'b0;
			end else begin
				case (state_q)
					S_IDLE: begin
						if (start_i) begin
							state_q  <= S_FETCH;
							active_q <= 1'b1;
							pc_q     <= '0;
						end
					end
					S_FETCH: state_q <= S_EXEC;
					S_EXEC: begin
						pc_q    <= pc_next;
						state_q <= S_FETCH;
						case (cmd_i.ch.op)
							OP_SHUTTER: shutter_q <= cmd_i.ch.mask;
							OP_TRIGGER: trigger_q <= cmd_i.ch.mask;
							OP_WAIT: begin
								if (timer_load_o) begin
									state_q <= S_WAIT;
								end
							end
							OP_END: begin
								pc_q     <= pc_q;
								state_q  <= S_IDLE;
								active_q <= 1'b0;
							end
							default: ;
						endcase
					end
					S_WAIT: begin
						if (timer_expired_i) begin
							state_q <= S_FETCH;
						end
					end
					default: state_q <= S_IDLE;
				endcase
			end
		end
	end

	assign active_o  = active_q;
	assign pc_o      = pc_q;
	assign shutter_o = shutter_q;
	assign trigger_o = trigger_q;

	// Trigger pulses only follow an execute cycle of a running program
	a_trig_in_run: assert property (@(posedge clk) disable iff (ti_reset)
		(trigger_o != '0) |-> active_o && $past(state_q == S_EXEC));

endmodule

//--- hw/pp_wait_timer.sv
`timescale 1ns/1ps

module pp_wait_timer
	import pp_cmd_pkg::*;
(
	input  logic              clk,
	input  logic              ti_reset,
	input  logic              load_i,
	input  logic [WAIT_W-1:0] count_i,
	input  logic              abort_i,
	output logic              expired_o
);

	logic [WAIT_W-1:0] cnt_q;
	logic              running_q;

	// Fires in the count-th cycle after the load cycle
	assign expired_o = running_q && (cnt_q == WAIT_W'(1)) && !abort_i;

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			cnt_q     <= '0;
			running_q <= 1'b0;
		end else if (abort_i) begin
			cnt_q     <= '0;
			running_q <= 1'b0;
		end else if (load_i) begin
			cnt_q     <= count_i;
			running_q <= (count_i != '0);
		end else if (running_q) begin
			cnt_q <= cnt_q - 1'b1;
			if (expired_o) begin
				running_q <= 1'b0;
			end
		end
	end

	// No expiry unless a load armed the counter
	a_load_first: assert property (@(posedge clk) disable iff (ti_reset)
		expired_o |-> $past(load_i) || $past(running_q));

endmodule

//--- hw/pp_output_stage.sv
`timescale 1ns/1ps

module pp_output_stage
	import pp_host_pkg::*;
(
	input  logic      clk,
	input  logic      ti_reset,
	input  host_cfg_t cfg_i,
	input  ch_mask_t  host_trig_i,
	input  ch_mask_t  seq_shutter_i,
	input  ch_mask_t  seq_trigger_i,
	input  logic      active_i,
	output ch_mask_t  shutter_o,
	output ch_mask_t  trigger_o
);

	localparam int HIST = 1 << DELAY_BITS;

	ch_mask_t hist_q [1:HIST-1];
	ch_mask_t taps [HIST];
	ch_mask_t seq_delayed;

	// Shutter history, entry k is k cycles old
	always_ff @(posedge clk) begin
		hist_q[1] <= seq_shutter_i;
		for (int k = 2; k < HIST; k++) begin
			hist_q[k] <= hist_q[k-1];
		end
	end

	always_comb begin
		taps[0] = seq_shutter_i;
		for (int k = 1; k < HIST; k++) begin
			taps[k] = hist_q[k];
		end
	end

	// Each channel taps the history at its own delay
	always_comb begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			seq_delayed[ch] = taps[cfg_i.delay[ch*DELAY_BITS +: DELAY_BITS]][ch];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output mux, selected by the undelayed active flag
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (ti_reset) begin
			shutter_o <= '0;
			trigger_o <= '0;
		end else begin
			shutter_o <= active_i ? seq_delayed : cfg_i.shutter;
			trigger_o <= active_i ? seq_trigger_i : host_trig_i;
		end
	end

endmodule

//--- hw/pulse_programmer.sv
`timescale 1ns/1ps

module pulse_programmer
	import pp_host_pkg::*;
	import pp_cmd_pkg::*;
#(
	parameter int CMD_DEPTH = 64
) (
	input  logic     clk,
	input  logic     ti_reset,
	input  apb_req_t apb_i,
	output apb_rsp_t apb_o,
	output ch_mask_t shutter_o,
	output ch_mask_t trigger_o,
	output logic     pp_active_o
);

	host_cfg_t             cfg;
	ch_mask_t              host_trig, seq_shutter, seq_trigger;
	logic                  start, stop, cmd_we;
	logic [CMD_ADDR_W-1:0] cmd_addr, fetch_addr, seq_pc;
	cmd_word_u             cmd_wdata, host_rdata, fetch_word;
	logic                  timer_load, timer_expired, seq_active;
	logic [WAIT_W-1:0]     timer_count;

	////////////////////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////////////////////
	pp_apb_regs #(.CMD_DEPTH(CMD_DEPTH)) regs_i (
		.clk(clk), .ti_reset(ti_reset), .apb_i(apb_i), .apb_o(apb_o),
		.cmd_rdata_i(host_rdata), .seq_active_i(seq_active), .seq_pc_i(seq_pc),
		.cfg_o(cfg), .host_trig_o(host_trig), .start_o(start), .stop_o(stop),
		.cmd_we_o(cmd_we), .cmd_addr_o(cmd_addr), .cmd_wdata_o(cmd_wdata)
	);

	// Host write and readback share one address
	pp_cmd_mem #(.CMD_DEPTH(CMD_DEPTH)) mem_i (
		.clk(clk), .we_i(cmd_we), .waddr_i(cmd_addr), .wdata_i(cmd_wdata),
		.host_raddr_i(cmd_addr), .fetch_addr_i(fetch_addr),
		.host_rdata_o(host_rdata), .fetch_data_o(fetch_word)
	);

	////////////////////////////////////////////////////////////////////////////
	// Program execution
	////////////////////////////////////////////////////////////////////////////
	pp_sequencer #(.CMD_DEPTH(CMD_DEPTH)) seq_i (
		.clk(clk), .ti_reset(ti_reset), .start_i(start), .stop_i(stop),
		.cmd_i(fetch_word), .timer_expired_i(timer_expired),
		.fetch_addr_o(fetch_addr), .timer_load_o(timer_load),
		.timer_count_o(timer_count), .active_o(seq_active), .pc_o(seq_pc),
		.shutter_o(seq_shutter), .trigger_o(seq_trigger)
	);

	// Stop aborts a pending wait
	pp_wait_timer timer_i (
		.clk(clk), .ti_reset(ti_reset), .load_i(timer_load),
		.count_i(timer_count), .abort_i(stop), .expired_o(timer_expired)
	);

	pp_output_stage out_i (
		.clk(clk), .ti_reset(ti_reset), .cfg_i(cfg), .host_trig_i(host_trig),
		.seq_shutter_i(seq_shutter), .seq_trigger_i(seq_trigger),
		.active_i(seq_active), .shutter_o(shutter_o), .trigger_o(trigger_o)
	);

	assign pp_active_o = seq_active;

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

// Free-running clock and a synchronous reset released after a number of edges
module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic ti_reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		ti_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		ti_reset = 1'b0;
	end

endmodule

//--- sim/tb_pulse_programmer.sv
`timescale 1ns/1ps

module tb_pulse_programmer
	import pp_host_pkg::*;
	import pp_cmd_pkg::*;
();

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 16;
	localparam int NUM_TESTS       = 5;
	localparam int TEST_BUDGET     = 4000;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_BUDGET;
	localparam int LONG_WAIT       = 1000;

	logic        clk, ti_reset;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	ch_mask_t    shutter, trigger;
	logic        active;
	logic [31:0] rng_state;
	int          err_count, tests_run;
	ch_mask_t    host_shutter;
	cmd_word_u   prog[$];

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_i (
		.clk(clk), .ti_reset(ti_reset)
	);

	pulse_programmer #(.CMD_DEPTH(64)) dut_i (
		.clk(clk), .ti_reset(ti_reset), .apb_i(apb_req), .apb_o(apb_rsp),
		.shutter_o(shutter), .trigger_o(trigger), .pp_active_o(active)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Bits 1:0 clear and bit 2 set, so host patterns never match the run patterns
	function automatic ch_mask_t host_pattern();
		logic [31:0] r;
		r = next_random();
		return (r[15:0] & 16'hfffc) | 16'h0004;
	endfunction

	function automatic cmd_word_u ch_cmd(input opcode_e op, input ch_mask_t mask);
		cmd_word_u w;
		w         = '0;
		w.ch.op   = op;
		w.ch.mask = mask;
		return w;
	endfunction

	function automatic cmd_word_u wait_cmd(input int cycles);
		cmd_word_u w;
		w          = '0;
		w.wt.op    = OP_WAIT;
		w.wt.count = WAIT_W'(cycles);
		return w;
	endfunction

	task automatic note_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		err_count++;
	endtask

	task automatic note_failure(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		err_count++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// No wait states, so pready is high in every access phase
	task automatic check_ready();
		if (apb_rsp.pready !== 1'b1) begin
			note_mismatch($sformatf("pready %b in the access phase, expected 1",
				apb_rsp.pready));
		end
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		next_cycle();
		apb_req.penable = 1'b1;
		#2;
		check_ready();
		next_cycle();
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		apb_req.pwdata  = '0;
		next_cycle();
		apb_req.penable = 1'b1;
		#2;
		check_ready();
		data = apb_rsp.prdata;
		next_cycle();
		apb_req = '0;
	endtask

	task automatic wait_active(input logic level, input int limit, output logic reached);
		reached = 1'b0;
		for (int i = 0; i <= limit; i++) begin
			if (active === level) begin
				reached = 1'b1;
				break;
			end
			next_cycle();
		end
	endtask

	task automatic wait_shutter(input ch_mask_t exp, input int limit, input string what);
		logic reached;
		reached = 1'b0;
		for (int i = 0; i <= limit; i++) begin
			if (shutter === exp) begin
				reached = 1'b1;
				break;
			end
			next_cycle();
		end
		if (!reached) begin
			note_mismatch($sformatf("%s: shutter_o %h, expected %h", what, shutter, exp));
		end
	endtask

	// Writes the program at CMD_BASE and reads every word back
	task automatic load_program();
		logic [31:0] rd;
		for (int i = 0; i < prog.size(); i++) begin
			apb_write(CMD_BASE + APB_AW'(4 * i), prog[i]);
		end
		for (int i = 0; i < prog.size(); i++) begin
			apb_read(CMD_BASE + APB_AW'(4 * i), rd);
			if (rd !== prog[i]) begin
				note_mismatch($sformatf("command %0d read %h, expected %h", i, rd, prog[i]));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////
	task automatic test_staged_registers();
		ch_mask_t    first, second;
		logic [31:0] rd;
		int          errs_before;
		errs_before = err_count;
		if (shutter !== '0 || trigger !== '0 || active !== 1'b0) begin
			note_mismatch("outputs not zero after reset");
		end
		first  = host_pattern();
		second = host_pattern();
		if (second == first) begin
			second = first ^ 16'h0010;
		end
		apb_write(REG_HOST_SHUTTER, 32'(first));
		// Staged only, the effective value stays at its reset value
		repeat (6) begin
			if (shutter !== '0) begin
				note_mismatch($sformatf("shutter_o %h changed before apply", shutter));
			end
			next_cycle();
		end
		apb_write(REG_CTRL, 32'h1 << CTRL_APPLY);
		wait_shutter(first, 3, "after apply");
		apb_write(REG_CONFIG, 32'h1 << CFG_APPLY_IMM);
		apb_write(REG_HOST_SHUTTER, 32'(second));
		wait_shutter(second, 3, "apply-immediately");
		host_shutter = second;
		apb_read(REG_HOST_SHUTTER, rd);
		if (rd !== 32'(second)) begin
			note_mismatch($sformatf("host shutter read %h, expected %h", rd, second));
		end
		finish_test("staged_registers", errs_before);
	endtask

	task automatic test_host_trigger();
		ch_mask_t    mask;
		logic [31:0] r;
		int          hits, errs_before;
		errs_before = err_count;
		r    = next_random();
		mask = r[15:0] | 16'h0001;
		apb_write(REG_TRIG_MASK, 32'(mask));
		apb_write(REG_CTRL, 32'h1 << CTRL_APPLY);
		repeat (3) next_cycle();
		apb_write(REG_CTRL, 32'h1 << CTRL_FIRE);
		hits = 0;
		repeat (8) begin
			if (trigger === mask) begin
				hits++;
			end else if (trigger !== '0) begin
				note_mismatch($sformatf("trigger_o %h, expected %h or zero", trigger, mask));
			end
			next_cycle();
		end
		if (hits != 1) begin
			note_mismatch($sformatf("trigger_o held the mask %0d cycles, expected 1", hits));
		end
		finish_test("host_trigger", errs_before);
	endtask

	task automatic test_program_run();
		ch_mask_t    shut_a, shut_b, trig_t;
		logic [31:0] r;
		logic        seen_active;
		int          wait_n, t_rise, t_a, t_b, t_fall, trig_hits, errs_before;
		errs_before = err_count;
		r      = next_random();
		shut_a = {r[15:1], 1'b1};
		shut_b = {r[31:18], 2'b10};
		r      = next_random();
		trig_t = r[15:0] | 16'h0001;
		wait_n = 5 + int'(r[20:16]);
		apb_write(REG_DELAY_LO, 32'h0);
		apb_write(REG_DELAY_HI, 32'h0);
		prog.delete();
		prog.push_back(ch_cmd(OP_SHUTTER, shut_a));
		prog.push_back(ch_cmd(OP_TRIGGER, trig_t));
		prog.push_back(wait_cmd(wait_n));
		prog.push_back(ch_cmd(OP_SHUTTER, shut_b));
		prog.push_back(ch_cmd(OP_END, '0));
		load_program();
		apb_write(REG_CTRL, 32'h1 << CTRL_START);
		seen_active = 1'b0;
		t_rise      = -1;
		t_a         = -1;
		t_b         = -1;
		t_fall      = -1;
		trig_hits   = 0;
		for (int cyc = 0; cyc < wait_n + 60 && t_fall < 0; cyc++) begin
			if (active === 1'b1 && !seen_active) begin
				seen_active = 1'b1;
				t_rise      = cyc;
			end else if (active === 1'b0 && seen_active) begin
				t_fall = cyc;
			end
			if (seen_active && t_a < 0 && shutter === shut_a) begin
				t_a = cyc;
			end
			if (t_a >= 0 && t_b < 0 && shutter === shut_b) begin
				t_b = cyc;
			end
			if (trigger === trig_t) begin
				trig_hits++;
			end else if (trigger !== '0) begin
				note_mismatch($sformatf("trigger_o %h during run", trigger));
			end
			next_cycle();
		end
		if (!seen_active || t_rise > 2) begin
			note_failure("pp_active_o did not rise within 2 cycles of the start write");
		end else if (t_a < 0 || t_b < 0) begin
			note_failure("shutter_o never showed both program patterns");
		end else if (t_b - t_a != 2 + (wait_n + 2) + 2) begin
			// TRIGGER, then WAIT n, then the second SHUTTER
			note_mismatch($sformatf("shutter a to b took %0d cycles, expected %0d",
				t_b - t_a, wait_n + 6));
		end
		if (trig_hits != 1) begin
			note_mismatch($sformatf("trigger_o showed the mask %0d cycles, expected 1",
				trig_hits));
		end
		if (t_fall < 0) begin
			note_failure("pp_active_o did not fall after END");
		end
		wait_shutter(host_shutter, 3, "after the run");
		finish_test("program_run", errs_before);
	endtask

	task automatic test_channel_delays();
		ch_delay_t   delays;
		logic [31:0] r_lo, r_hi;
		logic        seen_active, flushed;
		int          rise [NUM_CH];
		int          errs_before;
		errs_before = err_count;
		r_lo   = next_random();
		r_hi   = next_random();
		delays = {r_hi, r_lo[31:4], 4'h0};
		apb_write(REG_DELAY_LO, delays[31:0]);
		apb_write(REG_DELAY_HI, delays[63:32]);
		// Leading SHUTTER 0 and WAIT flush the history of the last run
		prog.delete();
		prog.push_back(ch_cmd(OP_SHUTTER, '0));
		prog.push_back(wait_cmd(20));
		prog.push_back(ch_cmd(OP_SHUTTER, '1));
		prog.push_back(wait_cmd(40));
		prog.push_back(ch_cmd(OP_END, '0));
		load_program();
		apb_write(REG_CTRL, 32'h1 << CTRL_START);
		seen_active = 1'b0;
		flushed     = 1'b0;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			rise[ch] = -1;
		end
		for (int cyc = 0; cyc < 200; cyc++) begin
			if (active === 1'b1) begin
				seen_active = 1'b1;
			end else if (seen_active) begin
				break;
			end
			if (seen_active && shutter === '0) begin
				flushed = 1'b1;
			end
			for (int ch = 0; ch < NUM_CH; ch++) begin
				if (flushed && rise[ch] < 0 && shutter[ch] === 1'b1) begin
					rise[ch] = cyc;
				end
			end
			next_cycle();
		end
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (rise[ch] < 0) begin
				note_failure($sformatf("shutter channel %0d never rose", ch));
			end else if (rise[ch] - rise[0] != int'(delays[ch*DELAY_BITS +: DELAY_BITS])) begin
				note_mismatch($sformatf("channel %0d rose %0d cycles after channel 0, expected %0d",
					ch, rise[ch] - rise[0], delays[ch*DELAY_BITS +: DELAY_BITS]));
			end
		end
		finish_test("channel_delays", errs_before);
	endtask

	task automatic test_stop_and_status();
		logic [31:0] rd;
		logic        reached;
		int          errs_before;
		errs_before = err_count;
		prog.delete();
		prog.push_back(wait_cmd(LONG_WAIT));
		prog.push_back(ch_cmd(OP_END, '0));
		load_program();
		apb_write(REG_CTRL, 32'h1 << CTRL_START);
		wait_active(1'b1, 4, reached);
		if (!reached) begin
			note_failure("pp_active_o did not rise after start");
		end
		apb_read(REG_STATUS, rd);
		if (rd[STAT_ACTIVE] !== 1'b1) begin
			note_mismatch($sformatf("status %h shows active clear during the wait", rd));
		end
		apb_write(REG_CTRL, 32'h1 << CTRL_STOP);
		wait_active(1'b0, 4, reached);
		if (!reached) begin
			note_failure("pp_active_o still high 4 cycles after stop");
		end
		apb_read(REG_STATUS, rd);
		if (rd[STAT_ACTIVE] !== 1'b0) begin
			note_mismatch($sformatf("status %h shows active set after stop", rd));
		end
		finish_test("stop_and_status", errs_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////////////////////
	initial begin
		apb_req      = '0;
		rng_state    = 32'h852a;
		err_count    = 0;
		tests_run    = 0;
		host_shutter = '0;
		@(negedge ti_reset);
		next_cycle();
		test_staged_registers();
		test_host_trigger();
		test_program_run();
		test_channel_delays();
		test_stop_and_status();
		$display("%0d tests run, %0d errors", tests_run, err_count);
		if (err_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("error: watchdog expired after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- all.f
hw/pp_host_pkg.sv
hw/pp_cmd_pkg.sv
hw/pp_apb_regs.sv
hw/pp_cmd_mem.sv
hw/pp_sequencer.sv
hw/pp_wait_timer.sv
hw/pp_output_stage.sv
hw/pulse_programmer.sv
sim/tb_clock.sv
sim/tb_pulse_programmer.sv

//--- run_sim.sh
#!/bin/sh
# Build the pulse programmer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_pulse_programmer -o tb_pulse_programmer &&
	./obj_dir/tb_pulse_programmer | tee /dev/stderr | grep -qF '** PASS **' &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
